//--- all.f
rtl/fetch_pkg.sv
rtl/decode_pkg.sv
rtl/fetch_window_if.sv
rtl/fetch_queue.sv
rtl/prefix_opcode_detect.sv
rtl/modrm_disp_detect.sv
rtl/decode_stage_0.sv
rtl/decode_front_top.sv
sim/decode_front_assert.sv
sim/decode_front_tb.sv

//--- Bender.yml
package:
  name: decode_front

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/decode_pkg.sv
      - rtl/fetch_window_if.sv
      - rtl/fetch_queue.sv
      - rtl/prefix_opcode_detect.sv
      - rtl/modrm_disp_detect.sv
      - rtl/decode_stage_0.sv
      - rtl/decode_front_top.sv
  - target: simulation
    files:
      - sim/decode_front_assert.sv
      - sim/decode_front_tb.sv

//--- sim/decode_front_tb.sv
/*
 * Decoder front testbench: directed byte streams through the fetch
 * port, checked against a length and field model of the opcode table
 */
`timescale 1ns/100ps
`default_nettype none

module decode_front_tb;
   import fetch_pkg::*;
   import decode_pkg::*;

   typedef struct packed {
      logic [LEN_W-1:0]  length;
      logic [1:0]        pfx_n;
      logic [PFX_W-1:0]  prefix;
      logic [1:0]        opc_n;
      logic [OPC_W-1:0]  opcode;
      opc_class_e        cls;
      logic [1:0]        adr_n;
      logic [ADR_W-1:0]  adr;
      logic [SZ_W-1:0]   disp_n;
      logic [SZ_W-1:0]   imm_n;
      logic [DI_W-1:0]   di;
      logic [IADDRW-1:0] pc;
   } exp_t;

   logic clk;
   logic arst_n;
   logic flush;
   logic [IADDRW-1:0] flush_pc;
   logic fetch_valid;
   logic fetch_ready;
   logic [31:0] fetch_data;
   logic s0_valid;
   logic s0_ready;
   logic [LEN_W-1:0] s0_length;
   logic [PFX_W-1:0] s0_prefix;
   logic [1:0] s0_prefix_bytes;
   logic [1:0] s0_opcode_bytes;
   logic [1:0] s0_addressing_bytes;
   logic [OPC_W-1:0] s0_opcode;
   logic [ADR_W-1:0] s0_addressing;
   logic [SZ_W-1:0] s0_displacement_bytes;
   logic [SZ_W-1:0] s0_immediate_bytes;
   logic [DI_W-1:0] s0_displace_n_imm;
   opc_class_e s0_opc_class;
   logic [IADDRW-1:0] s0_pc;

   logic [7:0] stream[$];
   exp_t exp_q[$];
   logic [IADDRW-1:0] next_pc;
   int errors;
   int checks;
   int cycles;
   integer seed;
   logic [31:0] rnd;
   logic bp_on;
   int hold_cnt;
   logic saw_full;

   decode_front_top DUT (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // Run limit, about four times the longest test
   always @(posedge clk) begin
      cycles++;
      if (cycles == 2000) begin
         $display("timeout after %0d cycles with %0d instructions still expected",
                  cycles, exp_q.size());
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("test failed");
         $finish;
      end
   end

   // Random stretches of s0_ready high and low
   always @(posedge clk) begin
      #1;
      if (bp_on) begin
         if (hold_cnt == 0) begin
            rnd = $random(seed);
            s0_ready = ~s0_ready;
            hold_cnt = rnd[3:0];
         end else begin
            hold_cnt--;
         end
      end
   end

   always @(negedge clk) begin
      if (arst_n && !fetch_ready) begin
         saw_full = 1'b1;
      end
      // Transfer happens on the coming rising edge
      if (arst_n && s0_valid && s0_ready && !flush) begin
         compare_insn();
      end
   end

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic compare_insn();
      exp_t e;
      assert (exp_q.size() != 0) else begin
         errors++;
         $display("unexpected instruction at pc %h with nothing left to decode", s0_pc);
      end
      if (exp_q.size() != 0) begin
         e = exp_q.pop_front();
         check_value("s0_pc", s0_pc, e.pc);
         check_value("s0_length", s0_length, e.length);
         check_value("s0_prefix_bytes", s0_prefix_bytes, e.pfx_n);
         check_value("s0_prefix", s0_prefix, e.prefix);
         check_value("s0_opcode_bytes", s0_opcode_bytes, e.opc_n);
         check_value("s0_opcode", s0_opcode, e.opcode);
         check_value("s0_opc_class", s0_opc_class, e.cls);
         check_value("s0_addressing_bytes", s0_addressing_bytes, e.adr_n);
         check_value("s0_addressing", s0_addressing, e.adr);
         check_value("s0_displacement_bytes", s0_displacement_bytes, e.disp_n);
         check_value("s0_immediate_bytes", s0_immediate_bytes, e.imm_n);
         check_value("s0_displace_n_imm", s0_displace_n_imm, e.di);
      end
   endtask

   function automatic logic [7:0] byte_at(input int k);
      return (k < stream.size()) ? stream[k] : 8'h00;
   endfunction

   // Reference decode of the instruction starting at stream offset p
   function automatic exp_t model_insn(input int p, input logic [IADDRW-1:0] pc);
      exp_t e;
      int k;
      int npfx;
      logic [7:0] op;
      logic [7:0] op2;
      logic [7:0] modrm;
      logic [7:0] sib;
      logic opsize;
      logic use_modrm;
      e = '0;
      e.pc = pc;
      k = p;
      npfx = 0;
      opsize = 1'b0;
      use_modrm = 1'b0;
      sib = 8'h00;
      while (npfx < MAX_PREFIX &&
             byte_at(k) inside {PFX_OPSIZE, PFX_REP, PFX_REPNE, PFX_CS, PFX_DS}) begin
         e.prefix[npfx*8 +: 8] = byte_at(k);
         opsize = opsize | (byte_at(k) == PFX_OPSIZE);
         npfx++;
         k++;
      end
      e.pfx_n = npfx;
      op = byte_at(k);
      op2 = byte_at(k + 1);
      e.cls = OPC_NONE;
      if (op == ESC_0F) begin
         e.opc_n = 2;
         e.opcode = {op2, op};
         k += 2;
         if (op2 >= 8'h80 && op2 <= 8'h8F) begin
            e.cls = OPC_0F_REL32;
            e.imm_n = 4;
         end else if (op2 == 8'hAF) begin
            e.cls = OPC_0F_RM;
            use_modrm = 1'b1;
         end
      end else begin
         e.opc_n = 1;
         e.opcode = {8'h00, op};
         k += 1;
         if (op inside {8'h01, 8'h03, 8'h89, 8'h8B}) begin
            e.cls = OPC_RM;
            use_modrm = 1'b1;
         end else if (op == 8'h83) begin
            e.cls = OPC_RM_IMM8;
            use_modrm = 1'b1;
            e.imm_n = 1;
         end else if (op >= 8'hB8 && op <= 8'hBF) begin
            e.cls = OPC_REG_IMM;
            e.imm_n = opsize ? 4'd2 : 4'd4;
         end else if (op == 8'hEB || (op >= 8'h70 && op <= 8'h7F)) begin
            e.cls = OPC_REL8;
            e.imm_n = 1;
         end else if (op == 8'hE9) begin
            e.cls = OPC_REL32;
            e.imm_n = 4;
         end
      end
      if (use_modrm) begin
         modrm = byte_at(k);
         e.adr_n = 1;
         e.adr = {8'h00, modrm};
         if (modrm[7:6] != 2'd3 && modrm[2:0] == 3'd4) begin
            sib = byte_at(k + 1);
            e.adr_n = 2;
            e.adr = {sib, modrm};
         end
         if (modrm[7:6] == 2'd1) begin
            e.disp_n = 1;
         end else if (modrm[7:6] == 2'd2) begin
            e.disp_n = 4;
         end else if (modrm[7:6] == 2'd0 && modrm[2:0] == 3'd5) begin
            e.disp_n = 4;
         end else if (modrm[7:6] == 2'd0 && e.adr_n == 2 && sib[2:0] == 3'd5) begin
            e.disp_n = 4;
         end
         k += e.adr_n;
      end
      for (int i = 0; i < e.disp_n + e.imm_n; i++) begin
         e.di[i*8 +: 8] = byte_at(k + i);
      end
      e.length = k + e.disp_n + e.imm_n - p;
      return e;
   endfunction

   // Bytes given most significant first, as they appear in memory
   task automatic add_insn(input int n, input logic [119:0] b);
      for (int i = n - 1; i >= 0; i--) begin
         stream.push_back(b[i*8 +: 8]);
      end
   endtask

   task automatic load_model();
      int p;
      exp_t e;
      // Pad to whole fetch words with NOPs
      while (stream.size() % FETCH_BYTES != 0) begin
         stream.push_back(8'h90);
      end
      p = 0;
      while (p < stream.size()) begin
         e = model_insn(p, next_pc);
         exp_q.push_back(e);
         p += e.length;
         next_pc += e.length;
      end
   endtask

   // fetch_ready only moves on a clock edge
   task automatic write_word(input logic [31:0] w);
      fetch_valid = 1'b1;
      fetch_data = w;
      while (!fetch_ready) begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);
      #1;
      fetch_valid = 1'b0;
   endtask

   task automatic send_words(input int gap);
      for (int i = 0; i < stream.size(); i += 4) begin
         write_word({stream[i+3], stream[i+2], stream[i+1], stream[i]});
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
      end
      stream.delete();
   endtask

   task automatic run_stream(input int gap);
      load_model();
      send_words(gap);
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      #1;
   endtask

   task automatic test_classes();
      add_insn(1, 8'h90);
      add_insn(1, 8'hC3);
      add_insn(2, 16'h01_C8);
      add_insn(3, 24'h83_C0_05);
      add_insn(5, 40'hB8_78_56_34_12);
      add_insn(2, 16'hEB_10);
      add_insn(2, 16'h74_FE);
      add_insn(5, 40'hE9_00_01_00_00);
      add_insn(6, 48'h0F_84_10_00_00_00);
      add_insn(3, 24'h0F_AF_C1);
      run_stream(0);
   endtask

   task automatic test_modrm();
      add_insn(3, 24'h8B_45_08);
      add_insn(6, 48'h89_85_00_01_00_00);
      add_insn(3, 24'h8B_04_24);
      add_insn(4, 32'h8B_44_24_10);
      add_insn(6, 48'h8B_05_78_56_34_12);
      add_insn(7, 56'h8B_04_25_44_33_22_11);
      add_insn(5, 40'h83_44_24_08_7F);
      add_insn(2, 16'h03_C3);
      run_stream(0);
   endtask

   task automatic test_prefix();
      add_insn(4, 32'h66_B8_34_12);
      add_insn(2, 16'hF3_90);
      add_insn(4, 32'h2E_3E_8B_00);
      add_insn(6, 48'h66_F2_2E_B8_22_11);
      add_insn(6, 48'h3E_E9_04_00_00_00);
      run_stream(0);
   endtask

   task automatic test_span();
      add_insn(11, 88'h66_2E_3E_83_84_24_00_01_00_00_7F);
      add_insn(6, 48'h0F_8F_00_10_00_00);
      add_insn(7, 56'h89_84_88_11_22_33_44);
      add_insn(10, 80'hF3_3E_2E_0F_AF_05_78_56_34_12);
      add_insn(5, 40'hB9_01_02_03_04);
      run_stream(3);
   endtask

   task automatic test_backpressure();
      saw_full = 1'b0;
      for (int n = 0; n < 20; n++) begin
         rnd = $random(seed);
         case (rnd[2:0])
            3'd0: add_insn(5, 40'hBA_44_33_22_11);
            3'd1: add_insn(4, 32'h8B_4C_24_08);
            3'd2: add_insn(2, 16'h75_F0);
            3'd3: add_insn(7, 56'h66_0F_AF_84_24_10_20);
            3'd4: add_insn(3, 24'h83_E8_01);
            default: add_insn(1, 8'h90);
         endcase
      end
      // First stretch long enough to fill the queue
      s0_ready = 1'b0;
      hold_cnt = 12;
      @(negedge clk);
      bp_on = 1'b1;
      @(posedge clk);
      #1;
      run_stream(0);
      bp_on = 1'b0;
      s0_ready = 1'b1;
      assert (saw_full) else begin
         errors++;
         $display("fetch_ready never fell while the output register was held");
      end
   endtask

   task automatic test_flush();
      s0_ready = 1'b0;
      add_insn(5, 40'hB8_01_00_00_00);
      add_insn(3, 24'h83_C1_01);
      add_insn(6, 48'hE9_00_00_00_00_90);
      load_model();
      send_words(0);
      repeat (3) begin
         @(posedge clk);
         #1;
      end
      flush = 1'b1;
      flush_pc = 32'h0000_8000;
      @(posedge clk);
      #1;
      flush = 1'b0;
      exp_q.delete();
      next_pc = flush_pc;
      check_value("s0_valid", s0_valid, 1'b0);
      s0_ready = 1'b1;
      add_insn(2, 16'h01_D8);
      add_insn(5, 40'hBB_0D_0C_0B_0A);
      run_stream(0);
   endtask

   initial begin
      seed = 32'h4cc34fd3;
      arst_n = 1'b0;
      flush = 1'b0;
      flush_pc = '0;
      fetch_valid = 1'b0;
      fetch_data = '0;
      s0_ready = 1'b1;
      bp_on = 1'b0;
      hold_cnt = 0;
      saw_full = 1'b0;
      next_pc = '0;
      errors = 0;
      checks = 0;
      cycles = 0;
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      check_value("s0_valid", s0_valid, 1'b0);
      check_value("fetch_ready", fetch_ready, 1'b1);
      test_classes();
      test_modrm();
      test_prefix();
      test_span();
      test_backpressure();
      test_flush();
      repeat (4) @(posedge clk);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/decode_front_assert.sv
/*
 * Handshake checks on the decoder front, bound to the top level
 */
`timescale 1ns/100ps
`default_nettype none

module decode_front_assert import fetch_pkg::*, decode_pkg::*; (
   input logic              clk,
   input logic              arst_n,
   input logic              flush,
   input logic              fetch_ready,
   input logic              s0_valid,
   input logic              s0_ready,
   input logic [LEN_W-1:0]  s0_length,
   input logic [PFX_W-1:0]  s0_prefix,
   input logic [BCNT_W-1:0] s0_prefix_bytes,
   input logic [BCNT_W-1:0] s0_opcode_bytes,
   input logic [BCNT_W-1:0] s0_addressing_bytes,
   input logic [OPC_W-1:0]  s0_opcode,
   input logic [ADR_W-1:0]  s0_addressing,
   input logic [SZ_W-1:0]   s0_displacement_bytes,
   input logic [SZ_W-1:0]   s0_immediate_bytes,
   input logic [DI_W-1:0]   s0_displace_n_imm,
   input logic [IADDRW-1:0] s0_pc
);

   logic [CNT_W-1:0] len_sum;

   assign len_sum = CNT_W'(s0_prefix_bytes) + CNT_W'(s0_opcode_bytes) +
                    CNT_W'(s0_addressing_bytes) + CNT_W'(s0_displacement_bytes) +
                    CNT_W'(s0_immediate_bytes);

   a_ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> fetch_ready)
      else $error("fetch_ready low after reset");

   a_flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> !s0_valid)
      else $error("s0_valid still high after flush");

   // Output register holds while the consumer stalls
   a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
      s0_valid && !s0_ready && !flush |=>
         $stable({s0_length, s0_prefix, s0_opcode, s0_addressing, s0_displace_n_imm, s0_pc}))
      else $error("s0 fields changed while stalled");

   // Field counts add up to a length of at most 15 bytes
   a_length_max: assert property (@(posedge clk) disable iff (!arst_n)
      s0_valid |-> (len_sum <= CNT_W'(MAX_INSN_LEN)) && (len_sum == CNT_W'(s0_length)))
      else $error("s0_length above the longest instruction or not the sum of its fields");

endmodule

bind decode_front_top decode_front_assert u_assert (.*);

`default_nettype wire

//--- rtl/decode_front_top.sv
/*
 * Decoder front: byte queue feeding decode stage 0 through the
 * fetch window
 */
`timescale 1ns/100ps
`default_nettype none

module decode_front_top import fetch_pkg::*, decode_pkg::*; (
   input  logic                    clk,
   input  logic                    arst_n,
   input  logic                    flush,
   input  logic [IADDRW-1:0]       flush_pc,

   input  logic                    fetch_valid,
   output logic                    fetch_ready,
   input  logic [FETCH_BYTES*8-1:0] fetch_data,

   output logic                    s0_valid,
   input  logic                    s0_ready,
   output logic [LEN_W-1:0]        s0_length,
   output logic [PFX_W-1:0]        s0_prefix,
   output logic [BCNT_W-1:0]       s0_prefix_bytes,
   output logic [BCNT_W-1:0]       s0_opcode_bytes,
   output logic [BCNT_W-1:0]       s0_addressing_bytes,
   output logic [OPC_W-1:0]        s0_opcode,
   output logic [ADR_W-1:0]        s0_addressing,
   output logic [SZ_W-1:0]         s0_displacement_bytes,
   output logic [SZ_W-1:0]         s0_immediate_bytes,
   output logic [DI_W-1:0]         s0_displace_n_imm,
   output opc_class_e              s0_opc_class,
   output logic [IADDRW-1:0]       s0_pc
);

   fetch_window_if win_if ();

   fetch_queue u_queue (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .flush_pc    (flush_pc),
      .fetch_valid (fetch_valid),
      .fetch_ready (fetch_ready),
      .fetch_data  (fetch_data),
      .win         (win_if.queue)
   );

   decode_stage_0 u_s0 (
      .clk                   (clk),
      .arst_n                (arst_n),
      .flush                 (flush),
      .win                   (win_if.decoder),
      .s0_valid              (s0_valid),
      .s0_ready              (s0_ready),
      .s0_length             (s0_length),
      .s0_prefix             (s0_prefix),
      .s0_prefix_bytes       (s0_prefix_bytes),
      .s0_opcode_bytes       (s0_opcode_bytes),
      .s0_addressing_bytes   (s0_addressing_bytes),
      .s0_opcode             (s0_opcode),
      .s0_addressing         (s0_addressing),
      .s0_displacement_bytes (s0_displacement_bytes),
      .s0_immediate_bytes    (s0_immediate_bytes),
      .s0_displace_n_imm     (s0_displace_n_imm),
      .s0_opc_class          (s0_opc_class),
      .s0_pc                 (s0_pc)
   );

endmodule

`default_nettype wire

//--- rtl/decode_stage_0.sv
/*
 * Decode stage 0: splits the instruction at the window head into
 * fields, sums its length, handshakes with the queue and registers it
 */
`timescale 1ns/100ps
`default_nettype none

module decode_stage_0 import fetch_pkg::*, decode_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              flush,

   fetch_window_if.decoder   win,

   output logic              s0_valid,
   input  logic              s0_ready,
   output logic [LEN_W-1:0]  s0_length,
   output logic [PFX_W-1:0]  s0_prefix,
   output logic [BCNT_W-1:0] s0_prefix_bytes,
   output logic [BCNT_W-1:0] s0_opcode_bytes,
   output logic [BCNT_W-1:0] s0_addressing_bytes,
   output logic [OPC_W-1:0]  s0_opcode,
   output logic [ADR_W-1:0]  s0_addressing,
   output logic [SZ_W-1:0]   s0_displacement_bytes,
   output logic [SZ_W-1:0]   s0_immediate_bytes,
   output logic [DI_W-1:0]   s0_displace_n_imm,
   output opc_class_e        s0_opc_class,
   output logic [IADDRW-1:0] s0_pc
);

   logic [WINDOW_BYTES*8-1:0] win_flat;
   logic [BCNT_W-1:0]         pfx_bytes, opc_bytes, adr_bytes;
   logic [PFX_W-1:0]          prefix;
   logic [OPC_W-1:0]          opcode;
   opc_class_e                opc_class;
   logic [SZ_W-1:0]           imm_bytes, disp_bytes;
   logic                      have_modrm;
   logic [CNT_W-1:0]          po_bytes, poa_bytes, di_bytes, length;
   logic [ADR_W-1:0]          adr_raw, adr_field;
   logic [DI_W-1:0]           di_raw, di_field;
   logic                      load;

   assign win_flat = win.window;

   prefix_opcode_detect u_pod (
      .bytes        (win.window[MAX_PREFIX+1:0]),
      .prefix_bytes (pfx_bytes),
      .opcode_bytes (opc_bytes),
      .prefix       (prefix),
      .opcode       (opcode),
      .opc_class    (opc_class),
      .imm_bytes    (imm_bytes),
      .have_modrm   (have_modrm)
   );

   // Addressing bytes start right after the opcode
   assign po_bytes = CNT_W'(pfx_bytes) + CNT_W'(opc_bytes);
   assign adr_raw  = ADR_W'(win_flat >> {po_bytes, 3'b000});

   modrm_disp_detect u_mdd (
      .addressing         (adr_raw),
      .have_modrm         (have_modrm),
      .addressing_bytes   (adr_bytes),
      .displacement_bytes (disp_bytes)
   );

   assign adr_field = (adr_bytes == 2'd2) ? adr_raw :
                      (adr_bytes == 2'd1) ? {8'h00, adr_raw[7:0]} : '0;

   // Displacement then immediate, zeroed past their end
   assign poa_bytes = po_bytes + CNT_W'(adr_bytes);
   assign di_bytes  = CNT_W'(disp_bytes) + CNT_W'(imm_bytes);
   assign di_raw    = DI_W'(win_flat >> {poa_bytes, 3'b000});

   always_comb begin
      for (int i = 0; i < DI_W / 8; i++) begin
         di_field[i*8 +: 8] = (CNT_W'(i) < di_bytes) ? di_raw[i*8 +: 8] : 8'h00;
      end
   end

   assign length = poa_bytes + di_bytes;

   // Wait for the whole instruction and a free output register
   assign win.ready      = (length <= win.valid_bytes) && (!s0_valid || s0_ready);
   assign win.bytes_read = length;
   assign load           = win.valid && win.ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s0_valid <= 1'b0;
      end else if (flush) begin
         s0_valid <= 1'b0;
      end else if (load) begin
         s0_valid <= 1'b1;
      end else if (s0_ready) begin
         s0_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         s0_length             <= LEN_W'(length);
         s0_prefix             <= prefix;
         s0_prefix_bytes       <= pfx_bytes;
         s0_opcode_bytes       <= opc_bytes;
         s0_addressing_bytes   <= adr_bytes;
         s0_opcode             <= opcode;
         s0_addressing         <= adr_field;
         s0_displacement_bytes <= disp_bytes;
         s0_immediate_bytes    <= imm_bytes;
         s0_displace_n_imm     <= di_field;
         s0_opc_class          <= opc_class;
         s0_pc                 <= win.pc;
      end
   end

endmodule

`default_nettype wire

//--- rtl/modrm_disp_detect.sv
/*
 * ModRM/SIB size detect: number of addressing bytes and the size
 * of the displacement that follows them
 */
`timescale 1ns/100ps
`default_nettype none

module modrm_disp_detect import decode_pkg::*; (
   input  logic [ADR_W-1:0]  addressing,
   input  logic              have_modrm,
   output logic [BCNT_W-1:0] addressing_bytes,
   output logic [SZ_W-1:0]   displacement_bytes
);

   logic [1:0] mod_f;
   logic [2:0] rm_f;
   logic [2:0] sib_base;
   logic       has_sib;

   // ModRM in the low byte, SIB in the high byte
   assign mod_f    = addressing[7:6];
   assign rm_f     = addressing[2:0];
   assign sib_base = addressing[10:8];

   assign has_sib = have_modrm && (mod_f != MOD_REG) && (rm_f == RM_SIB);

   always_comb begin
      addressing_bytes   = '0;
      displacement_bytes = '0;
      if (have_modrm) begin
         addressing_bytes = has_sib ? BCNT_W'(2) : BCNT_W'(1);
         case (mod_f)
            2'd1: displacement_bytes = SZ_W'(1);
            2'd2: displacement_bytes = SZ_W'(4);
            2'd0: begin
               // Absolute disp32, or SIB with no base register
               if (rm_f == RM_DISP32) begin
                  displacement_bytes = SZ_W'(4);
               end else if (has_sib && sib_base == RM_DISP32) begin
                  displacement_bytes = SZ_W'(4);
               end
            end
            default: displacement_bytes = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/prefix_opcode_detect.sv
/*
 * Prefix and opcode detect: counts leading prefixes, picks the opcode,
 * classifies it and sizes its immediate and ModRM need
 */
`timescale 1ns/100ps
`default_nettype none

module prefix_opcode_detect import decode_pkg::*; (
   input  logic [MAX_PREFIX+1:0][7:0] bytes,
   output logic [BCNT_W-1:0]          prefix_bytes,
   output logic [BCNT_W-1:0]          opcode_bytes,
   output logic [PFX_W-1:0]           prefix,
   output logic [OPC_W-1:0]           opcode,
   output opc_class_e                 opc_class,
   output logic [SZ_W-1:0]            imm_bytes,
   output logic                       have_modrm
);

   logic       in_pfx;
   logic       opsize;
   logic [7:0] op_lo;
   logic [7:0] op_hi;
   logic       esc;

   function automatic logic is_prefix(input logic [7:0] b);
      return b inside {PFX_OPSIZE, PFX_REP, PFX_REPNE, PFX_CS, PFX_DS};
   endfunction

   // Leading run of prefix bytes, three at most
   always_comb begin
      in_pfx       = 1'b1;
      opsize       = 1'b0;
      prefix_bytes = '0;
      prefix       = '0;
      for (int i = 0; i < MAX_PREFIX; i++) begin
         if (in_pfx && is_prefix(bytes[i])) begin
            prefix_bytes     = prefix_bytes + 1'b1;
            prefix[i*8 +: 8] = bytes[i];
            if (bytes[i] == PFX_OPSIZE) begin
               opsize = 1'b1;
            end
         end else begin
            in_pfx = 1'b0;
         end
      end
   end

   assign op_lo = bytes[3'(prefix_bytes)];
   assign op_hi = bytes[3'(prefix_bytes) + 3'd1];
   assign esc   = (op_lo == ESC_0F);

   assign opcode_bytes = esc ? BCNT_W'(2) : BCNT_W'(1);
   assign opcode       = esc ? {op_hi, op_lo} : {8'h00, op_lo};

   always_comb begin
      opc_class = OPC_NONE;
      if (esc) begin
         if (op_hi[7:4] == 4'h8) begin
            opc_class = OPC_0F_REL32;
         end else if (op_hi == 8'hAF) begin
            opc_class = OPC_0F_RM;
         end
      end else begin
         casez (op_lo)
            8'h01, 8'h03, 8'h89, 8'h8B: opc_class = OPC_RM;
            8'h83:                      opc_class = OPC_RM_IMM8;
            8'b1011_1???:               opc_class = OPC_REG_IMM;
            8'hEB, 8'b0111_????:        opc_class = OPC_REL8;
            8'hE9:                      opc_class = OPC_REL32;
            default:                    opc_class = OPC_NONE;
         endcase
      end
   end

   always_comb begin
      case (opc_class)
         OPC_RM_IMM8, OPC_REL8:   imm_bytes = SZ_W'(1);
         // Operand size prefix gives a 16-bit immediate
         OPC_REG_IMM:             imm_bytes = opsize ? SZ_W'(2) : SZ_W'(4);
         OPC_REL32, OPC_0F_REL32: imm_bytes = SZ_W'(4);
         default:                 imm_bytes = '0;
      endcase
   end

   assign have_modrm = (opc_class inside {OPC_RM, OPC_RM_IMM8, OPC_0F_RM});

endmodule

`default_nettype wire

//--- rtl/fetch_queue.sv
/*
 * Fetch queue: circular byte buffer filled one 32-bit word at a time,
 * read as a 16-byte window from the head, drained by a variable count
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_queue import fetch_pkg::*; (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   flush,
   input  logic [IADDRW-1:0]      flush_pc,

   input  logic                   fetch_valid,
   output logic                   fetch_ready,
   input  logic [FETCH_BYTES*8-1:0] fetch_data,

   fetch_window_if.queue          win
);

   logic [7:0]        mem [QUEUE_BYTES];

   logic [PTR_W-1:0]  head;
   logic [PTR_W-1:0]  tail;
   logic [CNT_W-1:0]  count;
   logic [IADDRW-1:0] pc;

   logic              wr_en;
   logic              rd_en;
   logic [CNT_W-1:0]  add_cnt;
   logic [CNT_W-1:0]  sub_cnt;

   // Room for one full fetch word
   assign fetch_ready = (count <= CNT_W'(QUEUE_BYTES - FETCH_BYTES));

   // Flush wins over both ports
   assign wr_en = fetch_valid && fetch_ready && !flush;
   assign rd_en = win.valid && win.ready && !flush;

   assign add_cnt = wr_en ? CNT_W'(FETCH_BYTES) : '0;
   assign sub_cnt = rd_en ? win.bytes_read : '0;

   // Byte storage, little endian within a fetch word
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < FETCH_BYTES; i++) begin
            mem[tail + PTR_W'(i)] <= fetch_data[i*8 +: 8];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         pc    <= '0;
      end else if (flush) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         pc    <= flush_pc;
      end else begin
         if (wr_en) begin
            tail <= tail + PTR_W'(FETCH_BYTES);
         end
         if (rd_en) begin
            head <= head + win.bytes_read[PTR_W-1:0];
            pc   <= pc + IADDRW'(win.bytes_read);
         end
         count <= count + add_cnt - sub_cnt;
      end
   end

   // Window gathered from the head with wrap-around
   always_comb begin
      for (int i = 0; i < WINDOW_BYTES; i++) begin
         if (CNT_W'(i) < count) begin
            win.window[i] = mem[head + PTR_W'(i)];
         end else begin
            win.window[i] = 8'h00;
         end
      end
   end

   assign win.valid       = (count != '0);
   assign win.valid_bytes = (count > CNT_W'(WINDOW_BYTES)) ? CNT_W'(WINDOW_BYTES) : count;
   assign win.pc          = pc;

endmodule

`default_nettype wire

//--- rtl/fetch_window_if.sv
/*
 * Fetch window: carries the oldest queue bytes, their count and
 * their PC to decode stage 0, which returns ready and bytes consumed
 */
`timescale 1ns/100ps
`default_nettype none

interface fetch_window_if import fetch_pkg::*; ();

   logic                         valid;
   // Byte 0 is the oldest unread byte
   logic [WINDOW_BYTES-1:0][7:0] window;
   logic [CNT_W-1:0]             valid_bytes;
   logic [IADDRW-1:0]            pc;

   logic                         ready;
   logic [CNT_W-1:0]             bytes_read;

   modport queue (
      output valid, window, valid_bytes, pc,
      input  ready, bytes_read
   );

   modport decoder (
      input  valid, window, valid_bytes, pc,
      output ready, bytes_read
   );

endinterface

`default_nettype wire

//--- rtl/decode_pkg.sv
/*
 * Decoder definitions: prefix bytes, opcode classes, field widths
 * and the ModRM/SIB codes behind the addressing size rules
 */
`default_nettype none

package decode_pkg;

   // Length limits
   localparam int MAX_PREFIX   = 3;
   localparam int MAX_INSN_LEN = 15;
   localparam int LEN_W        = $clog2(MAX_INSN_LEN + 1);

   // Field widths of the stage 0 output
   localparam int PFX_W  = 8 * MAX_PREFIX;
   localparam int OPC_W  = 16;
   localparam int ADR_W  = 16;
   localparam int DI_W   = 64;
   localparam int BCNT_W = 2;
   localparam int SZ_W   = 4;

   // Recognised prefix bytes
   localparam logic [7:0] PFX_OPSIZE = 8'h66;
   localparam logic [7:0] PFX_REP    = 8'hF3;
   localparam logic [7:0] PFX_REPNE  = 8'hF2;
   localparam logic [7:0] PFX_CS     = 8'h2E;
   localparam logic [7:0] PFX_DS     = 8'h3E;

   // Two-byte opcode escape
   localparam logic [7:0] ESC_0F = 8'h0F;

   // ModRM and SIB codes used by the addressing size rules
   localparam logic [1:0] MOD_REG    = 2'd3;
   localparam logic [2:0] RM_SIB     = 3'd4;
   localparam logic [2:0] RM_DISP32  = 3'd5;

   typedef enum logic [2:0] {
      OPC_NONE,
      OPC_RM,
      OPC_RM_IMM8,
      OPC_REG_IMM,
      OPC_REL8,
      OPC_REL32,
      OPC_0F_REL32,
      OPC_0F_RM
   } opc_class_e;

endpackage

`default_nettype wire

//--- rtl/fetch_pkg.sv
/*
 * Fetch path definitions: address width, byte queue depth,
 * decode window size and fetch word size
 */
`default_nettype none

package fetch_pkg;

   localparam int IADDRW = 32;

   // Byte queue and window geometry
   localparam int QUEUE_BYTES  = 32;
   localparam int WINDOW_BYTES = 16;
   localparam int FETCH_BYTES  = 4;

   // Counts reach QUEUE_BYTES, so one bit more than the pointer
   localparam int CNT_W = 6;
   localparam int PTR_W = $clog2(QUEUE_BYTES);

endpackage

`default_nettype wire
